//--- rtl/monitor_params.svh
`ifndef MONITOR_PARAMS_SVH
`define MONITOR_PARAMS_SVH

// widths
`define STAT_DATA_W       32
`define STAT_ADDR_W       8
`define STAT_SEL_W        2
`define STATUS_ADDR_W     30
`define PDUMETA_W         28
`define FILL_W            32
`define NUM_FILL_CH       3

// bank select of this block
`define TOP_REG           2'd0

// register offsets in the top bank
`define REG_IN_PKT        8'h01
`define REG_OUT_PKT       8'h02
`define REG_CPU_MATCH     8'h03
`define REG_CPU_NOMATCH   8'h04
`define REG_MAX_FILL_BASE 8'h10
`define REG_CTRL          8'h20

`endif

//--- rtl/stats_pkg.sv
`include "monitor_params.svh"

package stats_pkg;

    // offset inside the top register bank
    typedef logic [`STAT_ADDR_W-1:0] stat_addr_t;

    // one published statistic with its register offset
    typedef struct packed {
        stat_addr_t              addr;
        logic [`STAT_DATA_W-1:0] value;
    } stats_rec_t;

endpackage

//--- rtl/pdu_pkg.sv
`include "monitor_params.svh"

package pdu_pkg;

    typedef logic [1:0] pdu_action_t;

    localparam pdu_action_t ACTION_NOMATCH = 2'd1;
    localparam pdu_action_t ACTION_MATCH   = 2'd2;

    // cpu metadata word with the action code on top
    typedef struct packed {
        pdu_action_t              action;
        logic [`PDUMETA_W-3:0]    rule_ptr;
    } pdu_meta_t;

endpackage

//--- rtl/traffic_counters.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module traffic_counters (
    input  logic                  clk_status,
    input  logic                  rst,
    input  logic                  in_valid_i,
    input  logic                  in_eop_i,
    input  logic                  out_valid_i,
    input  logic                  out_eop_i,
    input  logic                  out_ready_i,
    input  logic                  pdumeta_valid_i,
    input  pdu_pkg::pdu_meta_t    pdumeta_data_i,
    input  logic                  rec_ready_i,
    output stats_pkg::stats_rec_t rec_o,
    output logic                  rec_valid_o
);
    import stats_pkg::*;
    import pdu_pkg::*;

    localparam int NUM_CNT = 4;

    logic [`STAT_DATA_W-1:0] cnt [NUM_CNT];
    logic [NUM_CNT-1:0]      inc;
    logic [1:0]              sweep_idx;
    stat_addr_t              sweep_addr;
    logic                    load_rec;

    // packet ends and cpu records by action
    assign inc[0] = in_valid_i & in_eop_i;
    assign inc[1] = out_valid_i & out_eop_i & out_ready_i;
    assign inc[2] = pdumeta_valid_i & (pdumeta_data_i.action == ACTION_MATCH);
    assign inc[3] = pdumeta_valid_i & (pdumeta_data_i.action == ACTION_NOMATCH);

    always_ff @(posedge clk_status) begin
        for (int i = 0; i < NUM_CNT; i++) begin
            if (rst) begin
                cnt[i] <= '0;
            end else if (inc[i]) begin
                cnt[i] <= cnt[i] + 1'b1;
            end
        end
    end

    always_comb begin
        case (sweep_idx)
            2'd0:    sweep_addr = `REG_IN_PKT;
            2'd1:    sweep_addr = `REG_OUT_PKT;
            2'd2:    sweep_addr = `REG_CPU_MATCH;
            default: sweep_addr = `REG_CPU_NOMATCH;
        endcase
    end

    // next record once the current one is taken
    assign load_rec = ~rec_valid_o | rec_ready_i;

    always_ff @(posedge clk_status) begin
        if (rst) begin
            rec_valid_o <= 1'b0;
            sweep_idx   <= '0;
        end else if (load_rec) begin
            rec_valid_o <= 1'b1;
            sweep_idx   <= sweep_idx + 1'b1;
        end
    end

    always_ff @(posedge clk_status) begin
        if (load_rec) begin
            rec_o.addr  <= sweep_addr;
            rec_o.value <= cnt[sweep_idx];
        end
    end

    // held record stays put until accepted
    assert property (@(posedge clk_status) disable iff (rst)
        rec_valid_o && !rec_ready_i |=> rec_valid_o && $stable(rec_o));

endmodule

//--- rtl/fill_watermark.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module fill_watermark (
    input  logic                                    clk_status,
    input  logic                                    rst,
    input  logic [`NUM_FILL_CH-1:0][`FILL_W-1:0]   fill_level_i,
    input  logic                                    rec_ready_i,
    output stats_pkg::stats_rec_t                   rec_o,
    output logic                                    rec_valid_o
);
    import stats_pkg::*;

    localparam int IDX_W = $clog2(`NUM_FILL_CH);

    logic [`FILL_W-1:0] max_q [`NUM_FILL_CH];
    logic [IDX_W-1:0]   sweep_idx;
    logic               load_rec;

    // running maximum per channel
    always_ff @(posedge clk_status) begin
        for (int ch = 0; ch < `NUM_FILL_CH; ch++) begin
            if (rst) begin
                max_q[ch] <= '0;
            end else if (fill_level_i[ch] > max_q[ch]) begin
                max_q[ch] <= fill_level_i[ch];
            end
        end
    end

    assign load_rec = ~rec_valid_o | rec_ready_i;

    always_ff @(posedge clk_status) begin
        if (rst) begin
            rec_valid_o <= 1'b0;
            sweep_idx   <= '0;
        end else if (load_rec) begin
            rec_valid_o <= 1'b1;
            // wrap after the last channel
            if (sweep_idx == IDX_W'(`NUM_FILL_CH - 1)) begin
                sweep_idx <= '0;
            end else begin
                sweep_idx <= sweep_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_status) begin
        if (load_rec) begin
            rec_o.addr  <= stat_addr_t'(`REG_MAX_FILL_BASE) + stat_addr_t'(sweep_idx);
            rec_o.value <= max_q[sweep_idx];
        end
    end

    for (genvar ch = 0; ch < `NUM_FILL_CH; ch++) begin : g_mono
        assert property (@(posedge clk_status) disable iff (rst)
            max_q[ch] >= $past(max_q[ch]));
    end

endmodule

//--- rtl/stats_arbiter.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module stats_arbiter (
    input  logic                  clk_status,
    input  logic                  rst,
    input  stats_pkg::stats_rec_t a_rec_i,
    input  logic                  a_valid_i,
    output logic                  a_ready_o,
    input  stats_pkg::stats_rec_t b_rec_i,
    input  logic                  b_valid_i,
    output logic                  b_ready_o,
    output stats_pkg::stats_rec_t rec_o,
    output logic                  rec_valid_o
);
    import stats_pkg::*;

    logic grant_b;
    logic sel_b;

    // b wins on its turn, or when a has nothing
    assign sel_b = b_valid_i & (grant_b | ~a_valid_i);

    assign a_ready_o   = a_valid_i & ~sel_b;
    assign b_ready_o   = sel_b;
    assign rec_o       = sel_b ? b_rec_i : a_rec_i;
    assign rec_valid_o = a_valid_i | b_valid_i;

    // sink takes every cycle, so any valid output is a transfer
    always_ff @(posedge clk_status) begin
        if (rst) begin
            grant_b <= 1'b0;
        end else if (rec_valid_o) begin
            grant_b <= ~sel_b;
        end
    end

    assert property (@(posedge clk_status) disable iff (rst)
        !(a_ready_o && b_ready_o));

endmodule

//--- rtl/stats_table.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module stats_table (
    input  logic                    clk_status,
    input  logic                    rst,
    input  stats_pkg::stats_rec_t   rec_i,
    input  logic                    rec_valid_i,
    input  stats_pkg::stat_addr_t   rd_addr_i,
    output logic [`STAT_DATA_W-1:0] rd_data_o
);
    import stats_pkg::*;

    localparam int DEPTH = 1 << `STAT_ADDR_W;

    logic [`STAT_DATA_W-1:0] regs [DEPTH];

    always_ff @(posedge clk_status) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (rec_valid_i) begin
            regs[rec_i.addr] <= rec_i.value;
        end
    end

    // combinational read for the csr front end
    assign rd_data_o = regs[rd_addr_i];

endmodule

//--- rtl/status_csr.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module status_csr (
    input  logic                      clk_status,
    input  logic                      rst,
    input  logic [`STATUS_ADDR_W-1:0] status_addr_i,
    input  logic                      status_read_i,
    input  logic                      status_write_i,
    input  logic [`STAT_DATA_W-1:0]   status_writedata_i,
    input  logic [`STAT_DATA_W-1:0]   table_data_i,
    output stats_pkg::stat_addr_t     table_addr_o,
    output logic [`STAT_DATA_W-1:0]   status_readdata_o,
    output logic                      status_readdata_valid_o
);
    import stats_pkg::*;

    logic [`STAT_SEL_W-1:0]  sel_r;
    stat_addr_t              offset_r;
    logic                    read_r;
    logic                    write_r;
    logic [`STAT_DATA_W-1:0] writedata_r;
    logic [`STAT_DATA_W-1:0] ctrl_q;
    logic                    top_sel;

    assign top_sel      = (sel_r == `TOP_REG);
    assign table_addr_o = offset_r;

    // registered bus strobes
    always_ff @(posedge clk_status) begin
        if (rst) begin
            read_r  <= 1'b0;
            write_r <= 1'b0;
        end else begin
            read_r  <= status_read_i;
            write_r <= status_write_i;
        end
    end

    // bank select from the top address bits
    always_ff @(posedge clk_status) begin
        sel_r       <= status_addr_i[`STATUS_ADDR_W-1 -: `STAT_SEL_W];
        offset_r    <= status_addr_i[`STAT_ADDR_W-1:0];
        writedata_r <= status_writedata_i;
    end

    always_ff @(posedge clk_status) begin
        if (rst) begin
            status_readdata_valid_o <= 1'b0;
            ctrl_q                  <= '0;
        end else begin
            status_readdata_valid_o <= read_r & top_sel;
            // other offsets in this bank clear ctrl
            if (write_r & top_sel) begin
                ctrl_q <= (offset_r == `REG_CTRL) ? writedata_r : '0;
            end
        end
    end

    always_ff @(posedge clk_status) begin
        if (read_r & top_sel) begin
            status_readdata_o <= (offset_r == `REG_CTRL) ? ctrl_q : table_data_i;
        end
    end

    assert property (@(posedge clk_status) disable iff (rst)
        status_readdata_valid_o |-> $past(read_r && top_sel));

endmodule

//--- rtl/pkt_monitor_top.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module pkt_monitor_top (
    input  logic                                  clk_status,
    input  logic                                  rst,
    input  logic                                  in_valid_i,
    input  logic                                  in_eop_i,
    input  logic                                  out_valid_i,
    input  logic                                  out_eop_i,
    input  logic                                  out_ready_i,
    input  logic                                  pdumeta_valid_i,
    input  pdu_pkg::pdu_meta_t                    pdumeta_data_i,
    input  logic [`NUM_FILL_CH-1:0][`FILL_W-1:0] fill_level_i,
    input  logic [`STATUS_ADDR_W-1:0]             status_addr_i,
    input  logic                                  status_read_i,
    input  logic                                  status_write_i,
    input  logic [`STAT_DATA_W-1:0]               status_writedata_i,
    output logic [`STAT_DATA_W-1:0]               status_readdata_o,
    output logic                                  status_readdata_valid_o
);
    import stats_pkg::*;

    stats_rec_t              tc_rec;
    logic                    tc_valid;
    logic                    tc_ready;
    stats_rec_t              fw_rec;
    logic                    fw_valid;
    logic                    fw_ready;
    stats_rec_t              arb_rec;
    logic                    arb_valid;
    stat_addr_t              table_addr;
    logic [`STAT_DATA_W-1:0] table_data;

    traffic_counters u_counters (
        .clk_status      (clk_status),
        .rst             (rst),
        .in_valid_i      (in_valid_i),
        .in_eop_i        (in_eop_i),
        .out_valid_i     (out_valid_i),
        .out_eop_i       (out_eop_i),
        .out_ready_i     (out_ready_i),
        .pdumeta_valid_i (pdumeta_valid_i),
        .pdumeta_data_i  (pdumeta_data_i),
        .rec_ready_i     (tc_ready),
        .rec_o           (tc_rec),
        .rec_valid_o     (tc_valid)
    );

    fill_watermark u_watermark (
        .clk_status   (clk_status),
        .rst          (rst),
        .fill_level_i (fill_level_i),
        .rec_ready_i  (fw_ready),
        .rec_o        (fw_rec),
        .rec_valid_o  (fw_valid)
    );

    stats_arbiter u_arbiter (
        .clk_status  (clk_status),
        .rst         (rst),
        .a_rec_i     (tc_rec),
        .a_valid_i   (tc_valid),
        .a_ready_o   (tc_ready),
        .b_rec_i     (fw_rec),
        .b_valid_i   (fw_valid),
        .b_ready_o   (fw_ready),
        .rec_o       (arb_rec),
        .rec_valid_o (arb_valid)
    );

    stats_table u_table (
        .clk_status  (clk_status),
        .rst         (rst),
        .rec_i       (arb_rec),
        .rec_valid_i (arb_valid),
        .rd_addr_i   (table_addr),
        .rd_data_o   (table_data)
    );

    status_csr u_csr (
        .clk_status              (clk_status),
        .rst                     (rst),
        .status_addr_i           (status_addr_i),
        .status_read_i           (status_read_i),
        .status_write_i          (status_write_i),
        .status_writedata_i      (status_writedata_i),
        .table_data_i            (table_data),
        .table_addr_o            (table_addr),
        .status_readdata_o       (status_readdata_o),
        .status_readdata_valid_o (status_readdata_valid_o)
    );

endmodule

//--- test/tb_pkt_monitor.sv
`timescale 1ns/1ps
`include "monitor_params.svh"

module tb_pkt_monitor;
    import pdu_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int READ_LATENCY = 2;
    localparam int READ_MAX     = 8;
    localparam int SETTLE       = 40;
    localparam int MAX_EVENTS   = 40;
    localparam int MAX_STEPS    = 12;
    localparam int NUM_READS    = 22;
    // every phase at its longest including reads and writes
    localparam int TEST_CYCLES  = NUM_READS * (READ_MAX + 2) + 3 * 2
                                + 2 * (MAX_EVENTS + 1 + SETTLE) + (MAX_STEPS + 2 + SETTLE);
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

    logic                                 clk_status = 1'b0;
    logic                                 rst;
    logic                                 in_valid_i;
    logic                                 in_eop_i;
    logic                                 out_valid_i;
    logic                                 out_eop_i;
    logic                                 out_ready_i;
    logic                                 pdumeta_valid_i;
    pdu_meta_t                            pdumeta_data_i;
    logic [`NUM_FILL_CH-1:0][`FILL_W-1:0] fill_level_i;
    logic [`STATUS_ADDR_W-1:0]            status_addr_i;
    logic                                 status_read_i;
    logic                                 status_write_i;
    logic [`STAT_DATA_W-1:0]              status_writedata_i;
    logic [`STAT_DATA_W-1:0]              status_readdata_o;
    logic                                 status_readdata_valid_o;

    int          checks = 0;
    int          errors = 0;
    int unsigned exp_in_pkt = 0;
    int unsigned exp_out_pkt = 0;
    int unsigned exp_match = 0;
    int unsigned exp_nomatch = 0;
    logic [`FILL_W-1:0] exp_max [`NUM_FILL_CH] = '{default: '0};

    pkt_monitor_top UUT (.*);

    always #(CLK_PERIOD / 2) clk_status = ~clk_status;

    function automatic logic chance(input int pct);
        return ($urandom_range(0, 99) < pct);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL at %0t: %s read 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // drive one read strobe and wait for the response pulse
    task automatic read_reg(input logic [1:0] sel, input logic [7:0] off,
                            output logic [31:0] data, output int lat, output bit seen);
        @(negedge clk_status);
        status_addr_i = {sel, {(`STATUS_ADDR_W - `STAT_SEL_W - `STAT_ADDR_W){1'b0}}, off};
        status_read_i = 1'b1;
        @(negedge clk_status);
        status_read_i = 1'b0;
        lat = 1;
        while (!status_readdata_valid_o && lat < READ_MAX) begin
            @(negedge clk_status);
            lat++;
        end
        seen = status_readdata_valid_o;
        data = status_readdata_o;
        checks++;
        assert (seen) else begin
            errors++;
            $display("read of offset 0x%02h got no response within %0d cycles", off, READ_MAX);
        end
    endtask

    task automatic check_reg(input logic [7:0] off, input logic [31:0] exp, input string what);
        logic [31:0] data;
        int          lat;
        bit          seen;
        read_reg(`TOP_REG, off, data, lat, seen);
        if (seen) begin
            check_value($sformatf("%s at 0x%02h", what, off), data, exp);
            // valid two cycles after the strobe is driven
            check_value($sformatf("latency at 0x%02h", off), lat, READ_LATENCY);
        end
    endtask

    task automatic write_reg(input logic [1:0] sel, input logic [7:0] off,
                             input logic [31:0] data);
        @(negedge clk_status);
        status_addr_i      = {sel, {(`STATUS_ADDR_W - `STAT_SEL_W - `STAT_ADDR_W){1'b0}}, off};
        status_writedata_i = data;
        status_write_i     = 1'b1;
        @(negedge clk_status);
        status_write_i = 1'b0;
    endtask

    task automatic expect_no_response(input logic [1:0] sel, input logic [7:0] off);
        @(negedge clk_status);
        status_addr_i = {sel, {(`STATUS_ADDR_W - `STAT_SEL_W - `STAT_ADDR_W){1'b0}}, off};
        status_read_i = 1'b1;
        @(negedge clk_status);
        status_read_i = 1'b0;
        repeat (4) begin
            checks++;
            assert (!status_readdata_valid_o) else begin
                errors++;
                $display("read in bank %0d at offset 0x%02h gave a response", sel, off);
            end
            @(negedge clk_status);
        end
    endtask

    task automatic check_reset_values();
        logic [7:0] offs [8];
        offs = '{`REG_IN_PKT, `REG_OUT_PKT, `REG_CPU_MATCH, `REG_CPU_NOMATCH,
                 `REG_MAX_FILL_BASE, `REG_MAX_FILL_BASE + 8'd1, `REG_MAX_FILL_BASE + 8'd2,
                 `REG_CTRL};
        foreach (offs[i]) begin
            check_reg(offs[i], 32'd0, "reset value");
        end
    endtask

    task automatic count_packets();
        int n;
        n = $urandom_range(10, MAX_EVENTS);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_status);
            in_valid_i  = chance(70);
            in_eop_i    = chance(40);
            out_valid_i = chance(70);
            out_eop_i   = chance(40);
            out_ready_i = chance(50);
            if (in_valid_i && in_eop_i) exp_in_pkt++;
            if (out_valid_i && out_eop_i && out_ready_i) exp_out_pkt++;
        end
        @(negedge clk_status);
        in_valid_i  = 1'b0;
        out_valid_i = 1'b0;
        repeat (SETTLE) @(negedge clk_status);
        check_reg(`REG_IN_PKT, exp_in_pkt, "input packets");
        check_reg(`REG_OUT_PKT, exp_out_pkt, "output packets");
    endtask

    task automatic count_cpu_records();
        int        n;
        pdu_meta_t meta;
        n = $urandom_range(10, MAX_EVENTS);
        for (int i = 0; i < n; i++) begin
            @(negedge clk_status);
            meta            = pdu_meta_t'($urandom);
            meta.action     = pdu_action_t'($urandom_range(0, 3));
            pdumeta_data_i  = meta;
            pdumeta_valid_i = chance(80);
            if (pdumeta_valid_i && meta.action == ACTION_MATCH) exp_match++;
            if (pdumeta_valid_i && meta.action == ACTION_NOMATCH) exp_nomatch++;
        end
        @(negedge clk_status);
        pdumeta_valid_i = 1'b0;
        repeat (SETTLE) @(negedge clk_status);
        check_reg(`REG_CPU_MATCH, exp_match, "cpu match");
        check_reg(`REG_CPU_NOMATCH, exp_nomatch, "cpu no-match");
    endtask

    task automatic track_watermarks();
        int steps;
        steps = $urandom_range(6, MAX_STEPS);
        for (int s = 0; s <= steps; s++) begin
            @(negedge clk_status);
            for (int ch = 0; ch < `NUM_FILL_CH; ch++) begin
                // last step drops every level low
                fill_level_i[ch] = (s == steps) ? $urandom_range(0, 15) : $urandom_range(0, 4095);
                if (fill_level_i[ch] > exp_max[ch]) exp_max[ch] = fill_level_i[ch];
            end
        end
        repeat (SETTLE) @(negedge clk_status);
        for (int ch = 0; ch < `NUM_FILL_CH; ch++) begin
            check_reg(`REG_MAX_FILL_BASE + 8'(ch), exp_max[ch], "max fill");
        end
    endtask

    task automatic exercise_ctrl_and_banks();
        logic [31:0] val;
        val = $urandom | 32'h1;
        write_reg(`TOP_REG, `REG_CTRL, val);
        check_reg(`REG_CTRL, val, "ctrl after write");
        write_reg(`TOP_REG, `REG_OUT_PKT, $urandom);
        check_reg(`REG_CTRL, 32'd0, "ctrl after other write");
        // table entries are not bus writable
        check_reg(`REG_OUT_PKT, exp_out_pkt, "output packets after write");
        write_reg(`TOP_REG, `REG_CTRL, val);
        expect_no_response(2'd1, `REG_CTRL);
        expect_no_response(2'd3, `REG_IN_PKT);
    endtask

    initial begin
        void'($urandom(2));
        rst                = 1'b1;
        in_valid_i         = 1'b0;
        in_eop_i           = 1'b0;
        out_valid_i        = 1'b0;
        out_eop_i          = 1'b0;
        out_ready_i        = 1'b0;
        pdumeta_valid_i    = 1'b0;
        pdumeta_data_i     = '0;
        fill_level_i       = '0;
        status_addr_i      = '0;
        status_read_i      = 1'b0;
        status_write_i     = 1'b0;
        status_writedata_i = '0;
        repeat (2) @(negedge clk_status);
        rst = 1'b0;
        check_reset_values();
        count_packets();
        count_cpu_records();
        track_watermarks();
        exercise_ctrl_and_banks();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_status);
        $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+rtl
rtl/stats_pkg.sv
rtl/pdu_pkg.sv
rtl/traffic_counters.sv
rtl/fill_watermark.sv
rtl/stats_arbiter.sv
rtl/stats_table.sv
rtl/status_csr.sv
rtl/pkt_monitor_top.sv
test/tb_pkt_monitor.sv

//--- Makefile
# Verilator build and run of the packet monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_pkt_monitor
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
